/* Makefile */
VERILATOR ?= verilator
TOP       ?= im_tb
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
SIM_BIN   ?= V$(TOP)
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  := Simulation finished: PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o $(SIM_BIN)

run: compile
	./$(BUILD_DIR)/$(SIM_BIN) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* hdl/im_ctl.sv */
`default_nettype none

module im_ctl import im_pkg::*; (
	input  wire               clk,
	input  wire               resetn,
	input  wire im_req_t      req,
	input  wire               go,
	input  wire               img_pulse,
	input  wire               img_valid,
	input  wire [IMG_W-1:0]   img_pos,
	output logic              rd_en,
	output logic [IMG_W-1:0]  rd_addr,
	input  wire [STEP_W-1:0]  rd_data,
	output motor_cmd_t        cmd,
	input  wire motor_sts_t   sts,
	output logic              exe_done
);
	move_mode_e             mode;
	run_state_e             state;
	logic [FRAME_CNT_W-1:0] dly_cnt;
	logic [STEP_W-1:0]      movie_pos;
	logic [5:1]             pen;
	logic [IMG_W:0]         sum_r;
	logic [IMG_W-1:0]       pos_l;
	logic [IMG_W-1:0]       pos_d;
	logic [IMG_W-1:0]       pos_r;
	logic [IMG_W-1:0]       pos_c;
	logic                   val_1;
	logic                   lofl_2;
	logic                   rofr_2;
	logic                   right_2;
	logic [IMG_W-1:0]       err_2;
	logic                   val_2;
	logic                   ok_3;
	logic                   back_3;
	logic                   val_3;
	logic                   ok_4;
	logic                   back_4;
	logic                   val_4;
	logic                   ok_5;
	logic                   over_5;
	logic [STEP_W-1:0]      dst_5;
	logic [STEP_W-1:0]      lut_5;
	logic                   val_5;
	logic                   plain_go;
	logic                   img_start;
	logic                   run_end;
	logic                   decide;
	logic                   at_dst;
	logic [STEP_W-1:0]      gap;
	logic                   start_q;
	logic                   stop_q;
	logic                   mod_q;
	logic                   dyn_adj;
	logic                   run_seen;
	logic [STEP_W-1:0]      speed_q;
	logic [STEP_W-1:0]      step_q;
	logic                   dir_q;
	logic [STEP_W-1:0]      new_remain_q;

	assign mode = req_mode(req);

	// motor position sampled a fixed delay after the exposure pulse
	always_ff @(posedge clk) begin
		if (!resetn)
			dly_cnt <= '0;
		else if (img_pulse)
			dly_cnt <= FRAME_CNT_W'(1);
		else if (dly_cnt == FRAME_CNT_W'(FRAME_DELAY))
			dly_cnt <= '0;
		else if (dly_cnt != '0)
			dly_cnt <= dly_cnt + 1'b1;
	end

	always_ff @(posedge clk) begin
		if (dly_cnt == FRAME_CNT_W'(FRAME_DELAY))
			movie_pos <= sts.position;
	end

	// frame valid, one bit per stage
	always_ff @(posedge clk) begin
		if (!resetn)
			pen <= '0;
		else
			pen <= {pen[4:1], img_pulse && (mode == MODE_IMAGE)};
	end

	// stage 1: tolerance window, clipped to the pixel range
	assign sum_r = {1'b0, req.img_dst} + {1'b0, req.img_tol};

	always_ff @(posedge clk) begin
		if (img_pulse) begin
			pos_l <= (req.img_dst >= req.img_tol) ? req.img_dst - req.img_tol : '0;
			pos_d <= req.img_dst;
			pos_r <= sum_r[IMG_W] ? '1 : sum_r[IMG_W-1:0];
			pos_c <= img_pos;
			val_1 <= img_valid;
		end
	end

	// stage 2: compares and absolute error
	always_ff @(posedge clk) begin
		if (pen[1]) begin
			lofl_2  <= pos_c < pos_l;
			rofr_2  <= pos_c > pos_r;
			right_2 <= pos_c > pos_d;
			err_2   <= (pos_c > pos_d) ? pos_c - pos_d : pos_d - pos_c;
			val_2   <= val_1;
		end
	end

	// stage 3: table lookup
	always_ff @(posedge clk) begin
		if (!resetn)
			rd_en <= 1'b0;
		else
			rd_en <= pen[2];
	end

	always_ff @(posedge clk) begin
		if (pen[2]) begin
			rd_addr <= err_2;
			ok_3    <= !lofl_2 && !rofr_2;
			back_3  <= right_2;
			val_3   <= val_2;
		end
	end

	// stage 4: flags wait for the RAM
	always_ff @(posedge clk) begin
		if (pen[3]) begin
			ok_4   <= ok_3;
			back_4 <= back_3;
			val_4  <= val_3;
		end
	end

	// stage 5: motor target from captured position and table entry
	always_ff @(posedge clk) begin
		if (pen[4]) begin
			ok_5   <= ok_4;
			over_5 <= !ok_4 && (back_4 != req.dir_back);
			dst_5  <= back_4 ? movie_pos - rd_data : movie_pos + rd_data;
			lut_5  <= rd_data;
			val_5  <= val_4;
		end
	end

	// decision stage
	assign plain_go  = go && (mode == MODE_PLAIN);
	assign img_start = !go && (state == ARMED) && pen[5] && !sts.running && !ok_5 && !over_5;
	assign run_end   = !go && (state == RUNNING) && run_seen && !sts.running;
	assign decide    = !go && (state == RUNNING) && pen[5] && sts.running;

	// positions may go below zero when moving back
	assign at_dst = dir_q ? ($signed(sts.position) <= $signed(dst_5)) :
	                        ($signed(sts.position) >= $signed(dst_5));
	assign gap    = dir_q ? sts.position - dst_5 : dst_5 - sts.position;

	always_ff @(posedge clk) begin
		if (!resetn) begin
			state    <= IDLE;
			start_q  <= 1'b0;
			stop_q   <= 1'b0;
			mod_q    <= 1'b0;
			dyn_adj  <= 1'b0;
			run_seen <= 1'b0;
			exe_done <= 1'b0;
		end else begin
			start_q <= plain_go || img_start;
			stop_q  <= decide && at_dst && !stop_q;
			mod_q   <= decide && !at_dst && dyn_adj && !mod_q;
			if (go) begin
				exe_done <= 1'b0;
				run_seen <= 1'b0;
				dyn_adj  <= 1'b0;
				state    <= (mode == MODE_PLAIN) ? RUNNING : ARMED;
			end else if (img_start) begin
				// no valid image position means run open ended and trim later
				dyn_adj <= !val_5;
				state   <= RUNNING;
			end else if (run_end) begin
				exe_done <= 1'b1;
				state    <= DONE;
			end else if (sts.running) begin
				run_seen <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (plain_go || img_start) begin
			speed_q <= req.speed;
			dir_q   <= req.dir_back;
			step_q  <= plain_go ? req.step : (val_5 ? lut_5 : '0);
		end
		if (decide && !at_dst)
			new_remain_q <= gap;
	end

	assign cmd = '{
		start:      start_q,
		stop:       stop_q,
		mod_remain: mod_q,
		speed:      speed_q,
		step:       step_q,
		dir:        dir_q,
		new_remain: new_remain_q
	};

	start_stop_excl: assert property (@(posedge clk) disable iff (!resetn)
		!(cmd.start && cmd.stop));

endmodule

`default_nettype wire

/* hdl/im_pkg.sv */
`default_nettype none

package im_pkg;

	// datapath widths
	localparam int IMG_W       = 8;
	localparam int STEP_W      = 32;
	localparam int WB_DW       = 32;
	localparam int ADR_W       = 10;
	localparam int LUT_DEPTH   = 256;
	localparam int LUT_AW      = $clog2(LUT_DEPTH);
	localparam int FRAME_DELAY = 3;
	localparam int FRAME_CNT_W = $clog2(FRAME_DELAY + 1);

	// word addresses
	localparam logic [ADR_W-1:0] REG_CTRL     = 10'd0;
	localparam logic [ADR_W-1:0] REG_STATUS   = 10'd1;
	localparam logic [ADR_W-1:0] REG_IMG_DST  = 10'd2;
	localparam logic [ADR_W-1:0] REG_IMG_TOL  = 10'd3;
	localparam logic [ADR_W-1:0] REG_SPEED    = 10'd4;
	localparam logic [ADR_W-1:0] REG_STEP     = 10'd5;
	localparam logic [ADR_W-1:0] REG_POSITION = 10'd6;
	localparam logic [ADR_W-1:0] LUT_BASE     = 10'd256;

	typedef enum logic {MODE_PLAIN, MODE_IMAGE} move_mode_e;

	typedef enum logic [1:0] {IDLE, ARMED, RUNNING, DONE} run_state_e;

	typedef struct packed {
		logic              single_dir;
		logic              dir_back;
		logic              dep_img;
		logic [IMG_W-1:0]  img_dst;
		logic [IMG_W-1:0]  img_tol;
		logic [STEP_W-1:0] speed;
		logic [STEP_W-1:0] step;
	} im_req_t;

	typedef struct packed {
		logic              start;
		logic              stop;
		logic              mod_remain;
		logic [STEP_W-1:0] speed;
		logic [STEP_W-1:0] step;
		logic              dir;
		logic [STEP_W-1:0] new_remain;
	} motor_cmd_t;

	typedef struct packed {
		logic              running;
		logic [STEP_W-1:0] position;
	} motor_sts_t;

	// image guidance only makes sense for a single-direction move
	function automatic move_mode_e req_mode(input im_req_t r);
		return (r.dep_img && r.single_dir) ? MODE_IMAGE : MODE_PLAIN;
	endfunction

endpackage

`default_nettype wire

/* hdl/im_top.sv */
`default_nettype none

module im_top import im_pkg::*; (
	input  wire               clk,
	input  wire               resetn,
	input  wire               wb_cyc,
	input  wire               wb_stb,
	input  wire               wb_we,
	input  wire [ADR_W-1:0]   wb_adr,
	input  wire [WB_DW-1:0]   wb_dat_w,
	output logic [WB_DW-1:0]  wb_dat_r,
	output logic              wb_ack,
	input  wire               img_pulse,
	input  wire               img_valid,
	input  wire [IMG_W-1:0]   img_pos,
	output logic              step_out,
	output logic              dir_out,
	output logic              enable
);
	im_req_t           req;
	logic              go;
	logic              lut_we;
	logic [LUT_AW-1:0] lut_waddr;
	logic [STEP_W-1:0] lut_wdata;
	logic              lut_re;
	logic [LUT_AW-1:0] lut_raddr;
	logic [STEP_W-1:0] lut_rdata;
	logic              rd_en;
	logic [IMG_W-1:0]  rd_addr;
	logic [STEP_W-1:0] rd_data;
	motor_cmd_t        cmd;
	motor_sts_t        sts;
	logic              exe_done;

	// driver enabled whenever out of reset
	assign enable = resetn;

	im_wb_regs u_regs (
		.clk       (clk),
		.resetn    (resetn),
		.wb_cyc    (wb_cyc),
		.wb_stb    (wb_stb),
		.wb_we     (wb_we),
		.wb_adr    (wb_adr),
		.wb_dat_w  (wb_dat_w),
		.wb_dat_r  (wb_dat_r),
		.wb_ack    (wb_ack),
		.req       (req),
		.go        (go),
		.lut_we    (lut_we),
		.lut_waddr (lut_waddr),
		.lut_wdata (lut_wdata),
		.lut_re    (lut_re),
		.lut_raddr (lut_raddr),
		.lut_rdata (lut_rdata),
		.sts       (sts),
		.exe_done  (exe_done)
	);

	pix_step_lut u_lut (
		.clk         (clk),
		.lut_we      (lut_we),
		.lut_waddr   (lut_waddr),
		.lut_wdata   (lut_wdata),
		.rd_en       (rd_en),
		.rd_addr     (rd_addr),
		.rd_data     (rd_data),
		.bus_rd_en   (lut_re),
		.bus_rd_addr (lut_raddr),
		.bus_rd_data (lut_rdata)
	);

	im_ctl u_ctl (
		.clk       (clk),
		.resetn    (resetn),
		.req       (req),
		.go        (go),
		.img_pulse (img_pulse),
		.img_valid (img_valid),
		.img_pos   (img_pos),
		.rd_en     (rd_en),
		.rd_addr   (rd_addr),
		.rd_data   (rd_data),
		.cmd       (cmd),
		.sts       (sts),
		.exe_done  (exe_done)
	);

	step_drive u_drive (
		.clk      (clk),
		.resetn   (resetn),
		.cmd      (cmd),
		.sts      (sts),
		.step_out (step_out),
		.dir_out  (dir_out)
	);

endmodule

`default_nettype wire

/* hdl/im_wb_regs.sv */
`default_nettype none

module im_wb_regs import im_pkg::*; (
	input  wire               clk,
	input  wire               resetn,
	input  wire               wb_cyc,
	input  wire               wb_stb,
	input  wire               wb_we,
	input  wire [ADR_W-1:0]   wb_adr,
	input  wire [WB_DW-1:0]   wb_dat_w,
	output logic [WB_DW-1:0]  wb_dat_r,
	output logic              wb_ack,
	output im_req_t           req,
	output logic              go,
	output logic              lut_we,
	output logic [LUT_AW-1:0] lut_waddr,
	output logic [STEP_W-1:0] lut_wdata,
	output logic              lut_re,
	output logic [LUT_AW-1:0] lut_raddr,
	input  wire [STEP_W-1:0]  lut_rdata,
	input  wire motor_sts_t   sts,
	input  wire               exe_done
);
	logic             access;
	logic             in_lut;
	logic             lut_rd_q;
	logic [WB_DW-1:0] reg_rdata;

	// one access per request, ack closes it
	assign access = wb_cyc && wb_stb && !wb_ack;
	assign in_lut = (wb_adr[ADR_W-1:LUT_AW] == LUT_BASE[ADR_W-1:LUT_AW]);

	// table window goes straight to the RAM ports
	assign lut_we    = access && wb_we && in_lut;
	assign lut_waddr = wb_adr[LUT_AW-1:0];
	assign lut_wdata = wb_dat_w;
	assign lut_re    = access && !wb_we && in_lut;
	assign lut_raddr = wb_adr[LUT_AW-1:0];

	// RAM output lands in the ack cycle
	assign wb_dat_r = lut_rd_q ? lut_rdata : reg_rdata;

	always_ff @(posedge clk) begin
		if (!resetn) begin
			wb_ack   <= 1'b0;
			lut_rd_q <= 1'b0;
			go       <= 1'b0;
			req      <= '0;
		end else begin
			wb_ack   <= wb_cyc && wb_stb && !wb_ack;
			lut_rd_q <= lut_re;
			go       <= 1'b0;
			if (access && wb_we) begin
				case (wb_adr)
					REG_CTRL: begin
						go             <= wb_dat_w[0];
						req.single_dir <= wb_dat_w[1];
						req.dir_back   <= wb_dat_w[2];
						req.dep_img    <= wb_dat_w[3];
					end
					REG_IMG_DST: req.img_dst <= wb_dat_w[IMG_W-1:0];
					REG_IMG_TOL: req.img_tol <= wb_dat_w[IMG_W-1:0];
					REG_SPEED:   req.speed   <= wb_dat_w;
					REG_STEP:    req.step    <= wb_dat_w;
					default: ;
				endcase
			end
		end
	end

	// readback, go always reads as zero
	always_ff @(posedge clk) begin
		if (access && !wb_we) begin
			case (wb_adr)
				REG_CTRL:     reg_rdata <= WB_DW'({req.dep_img, req.dir_back, req.single_dir, 1'b0});
				REG_STATUS:   reg_rdata <= WB_DW'({sts.running, exe_done});
				REG_IMG_DST:  reg_rdata <= WB_DW'(req.img_dst);
				REG_IMG_TOL:  reg_rdata <= WB_DW'(req.img_tol);
				REG_SPEED:    reg_rdata <= req.speed;
				REG_STEP:     reg_rdata <= req.step;
				REG_POSITION: reg_rdata <= sts.position;
				default:      reg_rdata <= '0;
			endcase
		end
	end

	// single-cycle ack, master must drop stb before the next access
	ack_one_cycle: assert property (@(posedge clk) disable iff (!resetn)
		wb_ack |=> !wb_ack);

endmodule

`default_nettype wire

/* hdl/pix_step_lut.sv */
`default_nettype none

module pix_step_lut import im_pkg::*; (
	input  wire               clk,
	input  wire               lut_we,
	input  wire [LUT_AW-1:0]  lut_waddr,
	input  wire [STEP_W-1:0]  lut_wdata,
	input  wire               rd_en,
	input  wire [IMG_W-1:0]   rd_addr,
	output logic [STEP_W-1:0] rd_data,
	input  wire               bus_rd_en,
	input  wire [LUT_AW-1:0]  bus_rd_addr,
	output logic [STEP_W-1:0] bus_rd_data
);
	// steps per pixel of error
	logic [STEP_W-1:0] mem [LUT_DEPTH];

	always_ff @(posedge clk) begin
		if (lut_we)
			mem[lut_waddr] <= lut_wdata;
	end

	// controller port
	always_ff @(posedge clk) begin
		if (rd_en)
			rd_data <= mem[rd_addr];
	end

	// software readback port
	always_ff @(posedge clk) begin
		if (bus_rd_en)
			bus_rd_data <= mem[bus_rd_addr];
	end

endmodule

`default_nettype wire

/* hdl/step_drive.sv */
`default_nettype none

module step_drive import im_pkg::*; (
	input  wire              clk,
	input  wire              resetn,
	input  wire motor_cmd_t  cmd,
	output motor_sts_t       sts,
	output logic             step_out,
	output logic             dir_out
);
	logic              running;
	logic              unlimited;
	logic [STEP_W-1:0] position;
	logic [STEP_W-1:0] remain;
	logic [STEP_W-1:0] period;
	logic [STEP_W-1:0] div_cnt;
	logic              tick;

	assign tick = running && (div_cnt == period - 1'b1);

	// at least two cycles per step so each pulse has a low phase
	always_ff @(posedge clk) begin
		if (cmd.start)
			period <= (cmd.speed < STEP_W'(2)) ? STEP_W'(2) : cmd.speed;
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			running   <= 1'b0;
			unlimited <= 1'b0;
			position  <= '0;
			remain    <= '0;
			div_cnt   <= '0;
			step_out  <= 1'b0;
			dir_out   <= 1'b0;
		end else begin
			step_out <= 1'b0;
			if (cmd.start) begin
				running   <= 1'b1;
				unlimited <= (cmd.step == '0);
				remain    <= cmd.step;
				dir_out   <= cmd.dir;
				div_cnt   <= '0;
			end else if (cmd.stop) begin
				running <= 1'b0;
			end else if (running) begin
				if (tick) begin
					div_cnt  <= '0;
					step_out <= 1'b1;
					position <= dir_out ? position - 1'b1 : position + 1'b1;
					if (!unlimited) begin
						remain <= remain - 1'b1;
						if (remain == STEP_W'(1))
							running <= 1'b0;
					end
				end else begin
					div_cnt <= div_cnt + 1'b1;
				end
				// trim overrides the countdown
				if (cmd.mod_remain) begin
					unlimited <= 1'b0;
					remain    <= cmd.new_remain;
					running   <= (cmd.new_remain != '0);
				end
			end
		end
	end

	assign sts = '{running: running, position: position};

	pos_on_step: assert property (@(posedge clk) disable iff (!resetn)
		!$stable(position) |-> step_out);

endmodule

`default_nettype wire

/* tb.f */
hdl/im_pkg.sv
hdl/pix_step_lut.sv
hdl/step_drive.sv
hdl/im_ctl.sv
hdl/im_wb_regs.sv
hdl/im_top.sv
verification/im_tb.sv

/* verification/im_tb.sv */
`default_nettype none

module im_tb import im_pkg::*; ();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int BUS_WAIT   = 16;
	localparam int DONE_READS = 4000;
	localparam int MAX_FRAMES = 400;
	localparam int RUN_LIMIT  = 200000;

	logic              clk;
	logic              resetn;
	logic              wb_cyc;
	logic              wb_stb;
	logic              wb_we;
	logic [ADR_W-1:0]  wb_adr;
	logic [WB_DW-1:0]  wb_dat_w;
	logic [WB_DW-1:0]  wb_dat_r;
	logic              wb_ack;
	logic              img_pulse;
	logic              img_valid;
	logic [IMG_W-1:0]  img_pos;
	logic              step_out;
	logic              dir_out;
	logic              enable;

	logic [STEP_W-1:0] lut_model [LUT_DEPTH];
	int                err_cnt;
	int                check_cnt;
	int                test_cnt;
	int                test_fail;
	int                test_err0;
	int                pulse_cnt;
	int                step_sum;
	logic              frames_stop;

	im_top UUT (
		.clk       (clk),
		.resetn    (resetn),
		.wb_cyc    (wb_cyc),
		.wb_stb    (wb_stb),
		.wb_we     (wb_we),
		.wb_adr    (wb_adr),
		.wb_dat_w  (wb_dat_w),
		.wb_dat_r  (wb_dat_r),
		.wb_ack    (wb_ack),
		.img_pulse (img_pulse),
		.img_valid (img_valid),
		.img_pos   (img_pos),
		.step_out  (step_out),
		.dir_out   (dir_out),
		.enable    (enable)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// motor pins seen from outside, like an encoder on the axis
	always @(posedge clk) begin
		if (step_out) begin
			pulse_cnt = pulse_cnt + 1;
			step_sum  = dir_out ? step_sum - 1 : step_sum + 1;
		end
	end

	initial begin
		repeat (RUN_LIMIT) @(posedge clk);
		$display("simulation time limit reached before the test sequence ended");
		$display("Simulation finished: FAIL");
		$finish;
	end

	// final axis position a run should reach
	function automatic logic [STEP_W-1:0] expected_final(input logic image,
			input logic [STEP_W-1:0] start, input logic dir_back,
			input logic [STEP_W-1:0] step, input logic [IMG_W-1:0] pos,
			input logic [IMG_W-1:0] dst, input logic [IMG_W-1:0] tol);
		logic             right;
		logic [IMG_W-1:0] err;
		if (!image)
			return dir_back ? start - step : start + step;
		right = pos > dst;
		err   = right ? pos - dst : dst - pos;
		// inside the window or mark on the wrong side, axis stays put
		if (err <= tol || right != dir_back)
			return start;
		return right ? start - lut_model[err] : start + lut_model[err];
	endfunction

	function automatic logic [STEP_W-1:0] clamp_window(input logic [STEP_W-1:0] got,
			input logic [STEP_W-1:0] exp);
		logic signed [STEP_W-1:0] diff;
		diff = $signed(got - exp);
		if (diff > 1)
			return exp + 1;
		if (diff < -1)
			return exp - 1;
		return got;
	endfunction

	function automatic logic [WB_DW-1:0] ctrl_word(input logic dep_img,
			input logic dir_back, input logic single_dir, input logic go);
		return {28'd0, dep_img, dir_back, single_dir, go};
	endfunction

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		check_cnt++;
		if (got !== exp) begin
			err_cnt++;
			$display("CHECK FAILED %s: got %h expected %h", name, got, exp);
		end
	endtask

	task automatic bus_cycle(input logic we, input logic [ADR_W-1:0] adr,
			input logic [WB_DW-1:0] wdata, output logic [WB_DW-1:0] rdata);
		int n;
		@(negedge clk);
		wb_cyc   = 1'b1;
		wb_stb   = 1'b1;
		wb_we    = we;
		wb_adr   = adr;
		wb_dat_w = wdata;
		n = 0;
		do begin
			@(negedge clk);
			n++;
		end while (!wb_ack && n < BUS_WAIT);
		if (!wb_ack) begin
			err_cnt++;
			$display("no wb_ack within %0d cycles at address %h", BUS_WAIT, adr);
		end
		rdata  = wb_dat_r;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we  = 1'b0;
	endtask

	task automatic reg_write(input logic [ADR_W-1:0] adr, input logic [WB_DW-1:0] data);
		logic [WB_DW-1:0] unused;
		bus_cycle(1'b1, adr, data, unused);
	endtask

	task automatic reg_read(input logic [ADR_W-1:0] adr, output logic [WB_DW-1:0] data);
		bus_cycle(1'b0, adr, '0, data);
	endtask

	task automatic send_frame(input logic [IMG_W-1:0] pos, input logic valid);
		@(negedge clk);
		img_pulse = 1'b1;
		img_pos   = pos;
		img_valid = valid;
		@(negedge clk);
		img_pulse = 1'b0;
	endtask

	task automatic wait_done();
		logic [WB_DW-1:0] st;
		int               n;
		n  = 0;
		st = '0;
		while (!st[0] && n < DONE_READS) begin
			reg_read(REG_STATUS, st);
			n++;
		end
		if (!st[0]) begin
			err_cnt++;
			$display("exe_done did not rise within %0d status reads", DONE_READS);
		end
	endtask

	// status sampled over a window, any running or done bit is remembered
	task automatic watch_idle(input int reads, output logic saw_run, output logic saw_done);
		logic [WB_DW-1:0] st;
		saw_run  = 1'b0;
		saw_done = 1'b0;
		repeat (reads) begin
			reg_read(REG_STATUS, st);
			saw_run  = saw_run | st[1];
			saw_done = saw_done | st[0];
		end
	endtask

	// camera model, the mark moves one pixel per motor step
	task automatic run_frames(input logic [IMG_W-1:0] p0);
		int k;
		int pix;
		k = 0;
		while (!frames_stop && k < MAX_FRAMES) begin
			pix = int'(p0) + step_sum;
			if (pix < 0)
				pix = 0;
			else if (pix > 255)
				pix = 255;
			send_frame(IMG_W'(pix), 1'b0);
			repeat (30) @(negedge clk);
			k++;
		end
		if (!frames_stop) begin
			err_cnt++;
			$display("camera model sent %0d frames and the run never ended", MAX_FRAMES);
		end
	endtask

	task automatic close_test(input string name);
		test_cnt++;
		if (err_cnt == test_err0) begin
			$display("test %0d %s: ok", test_cnt, name);
		end else begin
			test_fail++;
			$display("test %0d %s: failed with %0d errors", test_cnt, name, err_cnt - test_err0);
		end
		test_err0 = err_cnt;
	endtask

	initial begin
		logic [WB_DW-1:0]  rd;
		logic [STEP_W-1:0] start;
		logic [STEP_W-1:0] final_pos;
		logic [STEP_W-1:0] exp_pos;
		logic [STEP_W-1:0] spd;
		logic [STEP_W-1:0] stp;
		logic [IMG_W-1:0]  dst;
		logic [IMG_W-1:0]  tol;
		logic [IMG_W-1:0]  err;
		logic [IMG_W-1:0]  pos;
		logic              back;
		logic              saw_run;
		logic              saw_done;
		int                idx;

		void'($urandom(8958));
		resetn      = 1'b0;
		wb_cyc      = 1'b0;
		wb_stb      = 1'b0;
		wb_we       = 1'b0;
		wb_adr      = '0;
		wb_dat_w    = '0;
		img_pulse   = 1'b0;
		img_valid   = 1'b0;
		img_pos     = '0;
		err_cnt     = 0;
		check_cnt   = 0;
		test_cnt    = 0;
		test_fail   = 0;
		test_err0   = 0;
		pulse_cnt   = 0;
		step_sum    = 0;
		frames_stop = 1'b0;
		repeat (16) @(negedge clk);
		// driver stays off while in reset
		check("enable", 32'(enable), 32'd0);
		resetn = 1'b1;
		repeat (2) @(negedge clk);
		check("enable", 32'(enable), 32'd1);

		// register file and table window
		dst = IMG_W'($urandom());
		tol = IMG_W'($urandom());
		spd = $urandom();
		stp = $urandom();
		reg_write(REG_IMG_DST, WB_DW'(dst));
		reg_write(REG_IMG_TOL, WB_DW'(tol));
		reg_write(REG_SPEED, spd);
		reg_write(REG_STEP, stp);
		reg_read(REG_IMG_DST, rd);
		check("IMG_DST", rd, WB_DW'(dst));
		reg_read(REG_IMG_TOL, rd);
		check("IMG_TOL", rd, WB_DW'(tol));
		reg_read(REG_SPEED, rd);
		check("SPEED", rd, spd);
		reg_read(REG_STEP, rd);
		check("STEP", rd, stp);
		reg_read(ADR_W'(7), rd);
		check("unmapped read", rd, '0);
		for (idx = 0; idx < LUT_DEPTH; idx++) begin
			lut_model[idx] = $urandom_range(40, 2);
			reg_write(ADR_W'(int'(LUT_BASE) + idx), lut_model[idx]);
		end
		repeat (16) begin
			idx = $urandom_range(LUT_DEPTH - 1, 0);
			reg_read(ADR_W'(int'(LUT_BASE) + idx), rd);
			check($sformatf("LUT[%0d]", idx), rd, lut_model[idx]);
		end
		close_test("register and table readback");

		// plain move
		spd  = $urandom_range(6, 2);
		stp  = $urandom_range(24, 1);
		back = 1'($urandom_range(1, 0));
		reg_write(REG_SPEED, spd);
		reg_write(REG_STEP, stp);
		reg_read(REG_POSITION, start);
		pulse_cnt = 0;
		step_sum  = 0;
		reg_write(REG_CTRL, ctrl_word(1'b0, back, 1'b0, 1'b1));
		wait_done();
		reg_read(REG_POSITION, final_pos);
		exp_pos = expected_final(1'b0, start, back, stp, '0, '0, '0);
		check("POSITION", final_pos, exp_pos);
		check("step_out pulses", 32'(pulse_cnt), stp);
		check("dir_out steps", 32'(step_sum), back ? -stp : stp);
		close_test("plain move");

		// image inside tolerance
		dst  = IMG_W'($urandom_range(150, 100));
		tol  = IMG_W'($urandom_range(8, 2));
		back = 1'($urandom_range(1, 0));
		err  = IMG_W'($urandom_range(int'(tol), 0));
		pos  = $urandom_range(1, 0) ? dst + err : dst - err;
		reg_write(REG_IMG_DST, WB_DW'(dst));
		reg_write(REG_IMG_TOL, WB_DW'(tol));
		reg_write(REG_SPEED, 32'd3);
		reg_read(REG_POSITION, start);
		pulse_cnt = 0;
		reg_write(REG_CTRL, ctrl_word(1'b1, back, 1'b1, 1'b1));
		send_frame(pos, 1'b1);
		watch_idle(24, saw_run, saw_done);
		reg_read(REG_POSITION, final_pos);
		check("running", 32'(saw_run), 32'd0);
		check("POSITION", final_pos, expected_final(1'b1, start, back, '0, pos, dst, tol));
		check("step_out pulses", 32'(pulse_cnt), 32'd0);
		close_test("image inside tolerance");

		// image outside tolerance, mark on the side that dir_back serves
		back = 1'($urandom_range(1, 0));
		err  = tol + IMG_W'($urandom_range(40, 1));
		pos  = back ? dst + err : dst - err;
		reg_read(REG_POSITION, start);
		pulse_cnt = 0;
		reg_write(REG_CTRL, ctrl_word(1'b1, back, 1'b1, 1'b1));
		send_frame(pos, 1'b1);
		wait_done();
		reg_read(REG_POSITION, final_pos);
		check("POSITION", final_pos, expected_final(1'b1, start, back, '0, pos, dst, tol));
		check("step_out pulses", 32'(pulse_cnt), lut_model[err]);
		close_test("image move with valid position");

		// mark on the other side
		back = 1'($urandom_range(1, 0));
		err  = tol + IMG_W'($urandom_range(40, 1));
		pos  = back ? dst - err : dst + err;
		reg_read(REG_POSITION, start);
		pulse_cnt = 0;
		reg_write(REG_CTRL, ctrl_word(1'b1, back, 1'b1, 1'b1));
		send_frame(pos, 1'b1);
		watch_idle(24, saw_run, saw_done);
		reg_read(REG_POSITION, final_pos);
		check("running", 32'(saw_run), 32'd0);
		check("exe_done", 32'(saw_done), 32'd0);
		check("POSITION", final_pos, expected_final(1'b1, start, back, '0, pos, dst, tol));
		close_test("image wrong direction");

		// dynamic adjust needs a table that matches the linear camera model
		for (idx = 0; idx < 64; idx++) begin
			lut_model[idx] = STEP_W'(idx);
			reg_write(ADR_W'(int'(LUT_BASE) + idx), lut_model[idx]);
		end
		dst  = IMG_W'($urandom_range(150, 100));
		tol  = IMG_W'($urandom_range(6, 2));
		err  = tol + IMG_W'($urandom_range(30, 6));
		spd  = 64 + $urandom_range(15, 0);
		back = 1'($urandom_range(1, 0));
		pos  = back ? dst + err : dst - err;
		reg_write(REG_IMG_DST, WB_DW'(dst));
		reg_write(REG_IMG_TOL, WB_DW'(tol));
		reg_write(REG_SPEED, spd);
		reg_read(REG_POSITION, start);
		step_sum    = 0;
		pulse_cnt   = 0;
		frames_stop = 1'b0;
		reg_write(REG_CTRL, ctrl_word(1'b1, back, 1'b1, 1'b1));
		fork
			run_frames(pos);
			begin
				wait_done();
				frames_stop = 1'b1;
			end
		join
		reg_read(REG_POSITION, final_pos);
		exp_pos = expected_final(1'b1, start, back, '0, pos, dst, tol);
		check("POSITION", final_pos, clamp_window(final_pos, exp_pos));
		close_test("dynamic adjust");

		$display("tests %0d, failed %0d, checks %0d, errors %0d",
			test_cnt, test_fail, check_cnt, err_cnt);
		if (err_cnt == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

`default_nettype wire
